//--- compile.f
cpu_pkg.sv
alu.sv
ctrl_unit.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
alu_pipeline_top.sv
tb_alu_pipeline.sv

//--- run.sh
#!/bin/sh
set -e

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_alu_pipeline -f compile.f -o sim_tb

out=$(./obj_dir/sim_tb 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "^Finished with no errors$"; then
    exit 0
fi
exit 1

//--- tb_alu_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module tb_alu_pipeline import cpu_pkg::*; ();

    localparam logic [6:0] OPCODE_REG = 7'b0110011;
    localparam logic [6:0] OPCODE_IMM = 7'b0010011;
    localparam int         NUM_RANDOM  = 300;
    localparam int         DRAIN_LIMIT = 20;

    logic      i_clk;
    logic      i_rst;
    logic      i_instr_vld;
    word_t     i_instr;
    logic      o_wb_vld;
    reg_addr_t o_wb_rd;
    word_t     o_wb_data;

    int        cyc;
    integer    seed;
    word_t     model [0:31];

    // Stimulus table with one entry per issue slot
    logic      tbl_vld[$];
    word_t     tbl_instr[$];
    logic      tbl_retire[$];
    reg_addr_t tbl_rd[$];
    word_t     tbl_val[$];

    // Outstanding retirements in issue order
    reg_addr_t exp_rd_q[$];
    word_t     exp_val_q[$];
    int        exp_cyc_q[$];

    alu_pipeline_top uut (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_instr_vld (i_instr_vld),
        .i_instr     (i_instr),
        .o_wb_vld    (o_wb_vld),
        .o_wb_rd     (o_wb_rd),
        .o_wb_data   (o_wb_data)
    );

    initial i_clk = 1'b0;
    always #20 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cyc <= cyc + 1;
    end

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input word_t exp, input word_t act);
        $display("FAIL time=%0t signal=%s expected=0x%08h actual=0x%08h",
                 $time, name, exp, act);
        stop_with_failure();
    endtask

    task automatic report_problem(input string what);
        $display("ERROR time=%0t %s", $time, what);
        stop_with_failure();
    endtask

    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPCODE_REG};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd);
        return {imm, rs1, f3, rd, OPCODE_IMM};
    endfunction

    // Reference results straight from the RV32I definitions
    function automatic word_t ref_alu(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        word_t res;
        case (f3)
            3'd0: res = alt ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5: begin
                if (alt) begin
                    res = $signed(a) >>> b[4:0];
                end else begin
                    res = a >> b[4:0];
                end
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    task automatic table_write(input word_t instr, input reg_addr_t rd, input word_t val);
        tbl_vld.push_back(1'b1);
        tbl_instr.push_back(instr);
        tbl_retire.push_back(1'b1);
        tbl_rd.push_back(rd);
        tbl_val.push_back(val);
    endtask

    task automatic table_silent(input word_t instr);
        tbl_vld.push_back(1'b1);
        tbl_instr.push_back(instr);
        tbl_retire.push_back(1'b0);
        tbl_rd.push_back(5'd0);
        tbl_val.push_back(32'h0);
    endtask

    task automatic table_gap();
        tbl_vld.push_back(1'b0);
        tbl_instr.push_back(32'hDEAD_BEEF);
        tbl_retire.push_back(1'b0);
        tbl_rd.push_back(5'd0);
        tbl_val.push_back(32'h0);
    endtask

    task automatic build_table();
        // Immediate forms seed x1 = 5 and x2 = -3
        table_write(enc_i(12'h005, 5'd0, 3'd0, 5'd1), 5'd1, 32'h0000_0005);
        table_write(enc_i(12'hFFD, 5'd0, 3'd0, 5'd2), 5'd2, 32'hFFFF_FFFD);
        table_write(enc_i(12'hFFE, 5'd2, 3'd2, 5'd3), 5'd3, 32'h0000_0001);
        table_write(enc_i(12'h005, 5'd2, 3'd3, 5'd4), 5'd4, 32'h0000_0000);
        table_write(enc_i(12'hFFF, 5'd1, 3'd4, 5'd5), 5'd5, 32'hFFFF_FFFA);
        table_write(enc_i(12'h0F0, 5'd1, 3'd6, 5'd6), 5'd6, 32'h0000_00F5);
        table_write(enc_i(12'h7FF, 5'd2, 3'd7, 5'd7), 5'd7, 32'h0000_07FD);
        table_write(enc_i(12'h01C, 5'd1, 3'd1, 5'd8), 5'd8, 32'h5000_0000);
        table_write(enc_i(12'h004, 5'd2, 3'd5, 5'd9), 5'd9, 32'h0FFF_FFFF);
        table_write(enc_i(12'h401, 5'd2, 3'd5, 5'd10), 5'd10, 32'hFFFF_FFFE);
        table_write(enc_i(12'hFFF, 5'd1, 3'd3, 5'd11), 5'd11, 32'h0000_0001);
        table_gap();
        // Dependent R-type chain at distances 1, 2 and 3
        table_write(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd12), 5'd12, 32'h0000_0002);
        table_write(enc_r(7'h20, 5'd1, 5'd12, 3'd0, 5'd13), 5'd13, 32'hFFFF_FFFD);
        table_write(enc_r(7'h00, 5'd12, 5'd1, 3'd1, 5'd14), 5'd14, 32'h0000_0014);
        table_write(enc_r(7'h00, 5'd12, 5'd13, 3'd2, 5'd15), 5'd15, 32'h0000_0001);
        table_write(enc_r(7'h00, 5'd13, 5'd12, 3'd3, 5'd16), 5'd16, 32'h0000_0001);
        table_write(enc_r(7'h00, 5'd15, 5'd14, 3'd4, 5'd17), 5'd17, 32'h0000_0015);
        table_write(enc_r(7'h00, 5'd12, 5'd13, 3'd5, 5'd18), 5'd18, 32'h3FFF_FFFF);
        table_write(enc_r(7'h20, 5'd12, 5'd13, 3'd5, 5'd19), 5'd19, 32'hFFFF_FFFF);
        table_write(enc_r(7'h00, 5'd18, 5'd17, 3'd6, 5'd20), 5'd20, 32'h3FFF_FFFF);
        table_write(enc_r(7'h00, 5'd17, 5'd19, 3'd7, 5'd21), 5'd21, 32'h0000_0015);
        // x0 targets, LUI and LW never retire
        table_silent(enc_i(12'h007, 5'd1, 3'd0, 5'd0));
        table_silent(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd0));
        table_silent({20'h12345, 5'd22, 7'b0110111});
        table_silent({12'h000, 5'd1, 3'd2, 5'd23, 7'b0000011});
        table_write(enc_r(7'h00, 5'd0, 5'd0, 3'd6, 5'd22), 5'd22, 32'h0000_0000);
        table_write(enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd23), 5'd23, 32'h0000_0005);
        table_gap();
        table_gap();
        table_write(enc_i(12'hFEB, 5'd21, 3'd0, 5'd24), 5'd24, 32'h0000_0000);
        table_write(enc_r(7'h20, 5'd1, 5'd0, 3'd0, 5'd25), 5'd25, 32'hFFFF_FFFB);
    endtask

    // A retiring write is due four cycles after its issue slot
    task automatic issue(input logic vld, input word_t instr, input logic retire,
                         input reg_addr_t rd, input word_t val);
        @(posedge i_clk);
        #2;
        i_instr_vld = vld;
        i_instr     = instr;
        if (retire) begin
            exp_rd_q.push_back(rd);
            exp_val_q.push_back(val);
            exp_cyc_q.push_back(cyc + 4);
            model[rd] = val;
        end
    endtask

    task automatic issue_random();
        word_t       r;
        logic [2:0]  f3;
        logic        alt;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        logic [11:0] imm;
        word_t       b;
        word_t       instr;
        r   = $random(seed);
        f3  = r[3:1];
        rd  = r[9:5];
        rs1 = r[14:10];
        imm = r[31:20];
        if (r[0]) begin
            // Shift immediates hold only shamt and the SRAI bit
            if (f3 == 3'd1 || f3 == 3'd5) begin
                alt = (f3 == 3'd5) && r[4];
                imm = {1'b0, alt, 5'b0, r[24:20]};
                b   = {27'b0, r[24:20]};
            end else begin
                alt = 1'b0;
                b   = {{20{imm[11]}}, imm};
            end
            instr = enc_i(imm, rs1, f3, rd);
        end else begin
            alt   = r[4] && (f3 == 3'd0 || f3 == 3'd5);
            instr = enc_r({1'b0, alt, 5'b0}, r[19:15], rs1, f3, rd);
            b     = model[r[19:15]];
        end
        issue(1'b1, instr, rd != 5'd0, rd, ref_alu(f3, alt, model[rs1], b));
    endtask

    // Write-back checker samples on the falling edge
    always @(negedge i_clk) begin
        if (o_wb_vld) begin
            assert (exp_rd_q.size() > 0)
                else report_problem("write-back seen with no instruction outstanding");
            assert (exp_cyc_q[0] == cyc)
                else report_problem("write-back appeared before its expected cycle");
            assert (o_wb_rd == exp_rd_q[0])
                else report_mismatch("o_wb_rd", {27'b0, exp_rd_q[0]}, {27'b0, o_wb_rd});
            assert (o_wb_data == exp_val_q[0])
                else report_mismatch("o_wb_data", exp_val_q[0], o_wb_data);
            void'(exp_rd_q.pop_front());
            void'(exp_val_q.pop_front());
            void'(exp_cyc_q.pop_front());
        end else if (exp_cyc_q.size() > 0) begin
            assert (exp_cyc_q[0] != cyc)
                else report_problem("expected write-back did not appear in its cycle");
        end
    end

    initial begin
        word_t gap;
        int    waited;
        seed        = 66833;
        cyc         = 0;
        i_rst       = 1'b1;
        i_instr_vld = 1'b0;
        i_instr     = '0;
        for (int k = 0; k < 32; k++) begin
            model[k] = '0;
        end
        build_table();

        repeat (5) @(posedge i_clk);
        #2;
        i_rst = 1'b0;
        assert (o_wb_rd == 5'd0 && o_wb_data == 32'h0)
            else report_problem("write-back outputs not cleared by reset");

        // Idle pipeline stays silent
        repeat (10) issue(1'b0, '0, 1'b0, 5'd0, '0);

        for (int n = 0; n < tbl_instr.size(); n++) begin
            issue(tbl_vld[n], tbl_instr[n], tbl_retire[n], tbl_rd[n], tbl_val[n]);
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            gap = $random(seed);
            if (gap[1:0] == 2'b00) begin
                issue(1'b0, gap, 1'b0, 5'd0, '0);
            end
            issue_random();
        end
        issue(1'b0, '0, 1'b0, 5'd0, '0);

        waited = 0;
        while (exp_rd_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge i_clk);
            waited++;
        end
        @(negedge i_clk);
        if (exp_rd_q.size() == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            report_problem("timed out with register writes still missing");
        end
    end

endmodule

`default_nettype wire

//--- alu_pipeline_top.sv
`timescale 1ns/1ps
`default_nettype none

module alu_pipeline_top import cpu_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_instr_vld,
    input  word_t     i_instr,
    output logic      o_wb_vld,
    output reg_addr_t o_wb_rd,
    output word_t     o_wb_data
);

    // ID/EX register contents
    logic      ex_vld;
    reg_addr_t ex_rd;
    reg_addr_t ex_rs1;
    reg_addr_t ex_rs2;
    word_t     ex_rs1_data;
    word_t     ex_rs2_data;
    word_t     ex_imm;
    alu_op_e   ex_alu_op;
    logic      ex_imm_sel;

    // Write-back port doubles as the retire outputs
    decode_stage u_decode (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_instr_vld    (i_instr_vld),
        .i_instr        (i_instr),
        .i_wb_vld       (o_wb_vld),
        .i_wb_rd        (o_wb_rd),
        .i_wb_data      (o_wb_data),
        .o_ex_vld       (ex_vld),
        .o_ex_rd        (ex_rd),
        .o_ex_rs1       (ex_rs1),
        .o_ex_rs2       (ex_rs2),
        .o_ex_rs1_data  (ex_rs1_data),
        .o_ex_rs2_data  (ex_rs2_data),
        .o_ex_imm       (ex_imm),
        .o_ex_alu_op    (ex_alu_op),
        .o_ex_imm_sel   (ex_imm_sel)
    );

    execute_stage u_execute (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_ex_vld       (ex_vld),
        .i_ex_rd        (ex_rd),
        .i_ex_rs1       (ex_rs1),
        .i_ex_rs2       (ex_rs2),
        .i_ex_rs1_data  (ex_rs1_data),
        .i_ex_rs2_data  (ex_rs2_data),
        .i_ex_imm       (ex_imm),
        .i_ex_alu_op    (ex_alu_op),
        .i_ex_imm_sel   (ex_imm_sel),
        .o_wb_vld       (o_wb_vld),
        .o_wb_rd        (o_wb_rd),
        .o_wb_data      (o_wb_data)
    );

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_ex_vld,
    input  reg_addr_t i_ex_rd,
    input  reg_addr_t i_ex_rs1,
    input  reg_addr_t i_ex_rs2,
    input  word_t     i_ex_rs1_data,
    input  word_t     i_ex_rs2_data,
    input  word_t     i_ex_imm,
    input  alu_op_e   i_ex_alu_op,
    input  logic      i_ex_imm_sel,
    output logic      o_wb_vld,
    output reg_addr_t o_wb_rd,
    output word_t     o_wb_data
);

    logic      mem_vld;
    reg_addr_t mem_rd;
    word_t     mem_data;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    word_t     op_a;
    word_t     rs2_val;
    word_t     op_b;
    word_t     alu_result;

    // Youngest producer wins, so MEM is checked before WB
    function automatic fwd_sel_e pick_src(
        input reg_addr_t rs,
        input logic      m_vld,
        input reg_addr_t m_rd,
        input logic      w_vld,
        input reg_addr_t w_rd
    );
        if (m_vld && m_rd == rs) begin
            return FWD_MEM;
        end else if (w_vld && w_rd == rs) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    function automatic word_t fwd_mux(
        input fwd_sel_e sel,
        input word_t    reg_val,
        input word_t    mem_val,
        input word_t    wb_val
    );
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign fwd_a = pick_src(i_ex_rs1, mem_vld, mem_rd, o_wb_vld, o_wb_rd);
    assign fwd_b = pick_src(i_ex_rs2, mem_vld, mem_rd, o_wb_vld, o_wb_rd);

    assign op_a    = fwd_mux(fwd_a, i_ex_rs1_data, mem_data, o_wb_data);
    assign rs2_val = fwd_mux(fwd_b, i_ex_rs2_data, mem_data, o_wb_data);
    assign op_b    = i_ex_imm_sel ? i_ex_imm : rs2_val;

    alu u_alu (
        .i_op     (i_ex_alu_op),
        .i_a      (op_a),
        .i_b      (op_b),
        .o_result (alu_result)
    );

    // EX/MEM register
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            mem_vld  <= 1'b0;
            mem_rd   <= '0;
            mem_data <= '0;
        end else begin
            mem_vld  <= i_ex_vld;
            mem_rd   <= i_ex_rd;
            mem_data <= alu_result;
        end
    end

    // MEM/WB register with nothing to do in MEM
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_wb_vld  <= 1'b0;
            o_wb_rd   <= '0;
            o_wb_data <= '0;
        end else begin
            o_wb_vld  <= mem_vld;
            o_wb_rd   <= mem_rd;
            o_wb_data <= mem_data;
        end
    end

    // A bubble or an x0 slot in EX/MEM must never feed an operand
    a_fwd_mem_live: assert property (@(posedge i_clk) disable iff (i_rst)
        (fwd_a == FWD_MEM || fwd_b == FWD_MEM) |-> (mem_vld && mem_rd != '0))
        else $error("execute_stage: MEM forward selected from an empty or x0 slot");

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_instr_vld,
    input  word_t     i_instr,
    input  logic      i_wb_vld,
    input  reg_addr_t i_wb_rd,
    input  word_t     i_wb_data,
    output logic      o_ex_vld,
    output reg_addr_t o_ex_rd,
    output reg_addr_t o_ex_rs1,
    output reg_addr_t o_ex_rs2,
    output word_t     o_ex_rs1_data,
    output word_t     o_ex_rs2_data,
    output word_t     o_ex_imm,
    output alu_op_e   o_ex_alu_op,
    output logic      o_ex_imm_sel
);

    logic       if_vld;
    word_t      if_instr;
    reg_addr_t  id_rs1;
    reg_addr_t  id_rs2;
    reg_addr_t  id_rd;
    logic [2:0] id_funct3;
    word_t      id_rs1_data;
    word_t      id_rs2_data;
    word_t      id_imm;
    logic       id_vld;
    alu_op_e    id_alu_op;
    logic       id_imm_sel;

    // IF/ID register
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            if_vld   <= 1'b0;
            if_instr <= '0;
        end else begin
            if_vld   <= i_instr_vld;
            if_instr <= i_instr;
        end
    end

    assign id_rs1    = if_instr[19:15];
    assign id_rs2    = if_instr[24:20];
    assign id_rd     = if_instr[11:7];
    assign id_funct3 = if_instr[14:12];

    // Shift immediates carry only the shamt, bit 30 selects SRA
    always_comb begin
        if (id_funct3 == F3_SLL || id_funct3 == F3_SRL_SRA) begin
            id_imm = {{(XLEN-SHAMT_W){1'b0}}, if_instr[20 +: SHAMT_W]};
        end else begin
            id_imm = {{(XLEN-12){if_instr[31]}}, if_instr[31:20]};
        end
    end

    ctrl_unit u_ctrl (
        .i_instr     (if_instr),
        .i_instr_vld (if_vld),
        .o_vld       (id_vld),
        .o_alu_op    (id_alu_op),
        .o_imm_sel   (id_imm_sel)
    );

    reg_file u_regs (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_wr_en     (i_wb_vld),
        .i_wr_addr   (i_wb_rd),
        .i_wr_data   (i_wb_data),
        .i_rs1_addr  (id_rs1),
        .i_rs2_addr  (id_rs2),
        .o_rs1_data  (id_rs1_data),
        .o_rs2_data  (id_rs2_data)
    );

    // ID/EX register, a bubble arrives with the valid bit low
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_ex_vld      <= 1'b0;
            o_ex_rd       <= '0;
            o_ex_rs1      <= '0;
            o_ex_rs2      <= '0;
            o_ex_rs1_data <= '0;
            o_ex_rs2_data <= '0;
            o_ex_imm      <= '0;
            o_ex_alu_op   <= ALU_ADD;
            o_ex_imm_sel  <= 1'b0;
        end else begin
            o_ex_vld      <= id_vld;
            o_ex_rd       <= id_rd;
            o_ex_rs1      <= id_rs1;
            o_ex_rs2      <= id_rs2;
            o_ex_rs1_data <= id_rs1_data;
            o_ex_rs2_data <= id_rs2_data;
            o_ex_imm      <= id_imm;
            o_ex_alu_op   <= id_alu_op;
            o_ex_imm_sel  <= id_imm_sel;
        end
    end

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_wr_en,
    input  reg_addr_t i_wr_addr,
    input  word_t     i_wr_data,
    input  reg_addr_t i_rs1_addr,
    input  reg_addr_t i_rs2_addr,
    output word_t     o_rs1_data,
    output word_t     o_rs2_data
);

    // x0 has no storage
    word_t regs [1:NUM_REGS-1];

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && i_wr_addr != '0) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Same-cycle write shows through to the reader
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (i_wr_en && i_wr_addr == addr) begin
            return i_wr_data;
        end
        return regs[addr];
    endfunction

    assign o_rs1_data = read_port(i_rs1_addr);
    assign o_rs2_data = read_port(i_rs2_addr);

    // Decode must have filtered x0 destinations long before write-back
    a_no_x0_write: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wr_en |-> i_wr_addr != '0)
        else $error("reg_file: write enable with rd = x0");

endmodule

`default_nettype wire

//--- ctrl_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_unit import cpu_pkg::*; (
    input  word_t   i_instr,
    input  logic    i_instr_vld,
    output logic    o_vld,
    output alu_op_e o_alu_op,
    output logic    o_imm_sel
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       bit30;
    reg_addr_t  rd;
    logic       is_op;
    logic       is_op_imm;

    assign opcode    = i_instr[6:0];
    assign funct3    = i_instr[14:12];
    assign bit30     = i_instr[30];
    assign rd        = i_instr[11:7];
    assign is_op     = (opcode == OPC_OP);
    assign is_op_imm = (opcode == OPC_OP_IMM);

    // A write to x0 retires nothing, so it is dropped here
    assign o_vld     = i_instr_vld && (is_op || is_op_imm) && (rd != '0);
    assign o_imm_sel = is_op_imm;

    always_comb begin
        o_alu_op = ALU_ADD;
        case (funct3)
            // ADDI has no SUB form, bit 30 is immediate data there
            F3_ADD_SUB: o_alu_op = (is_op && bit30) ? ALU_SUB : ALU_ADD;
            F3_SLL:     o_alu_op = ALU_SLL;
            F3_SLT:     o_alu_op = ALU_SLT;
            F3_SLTU:    o_alu_op = ALU_SLTU;
            F3_XOR:     o_alu_op = ALU_XOR;
            F3_SRL_SRA: o_alu_op = bit30 ? ALU_SRA : ALU_SRL;
            F3_OR:      o_alu_op = ALU_OR;
            F3_AND:     o_alu_op = ALU_AND;
            default:    o_alu_op = ALU_ADD;
        endcase
    end

    // Valid instructions must leave decode with a clean operation
    always_comb begin
        if (o_vld) begin
            assert (!$isunknown(o_alu_op))
                else $error("ctrl_unit: unknown ALU op on a valid instruction");
        end
    end

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  alu_op_e i_op,
    input  word_t   i_a,
    input  word_t   i_b,
    output word_t   o_result
);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    // Shift amount from the low bits of operand B
    assign shamt       = i_b[SHAMT_W-1:0];
    assign lt_signed   = $signed(i_a) < $signed(i_b);
    assign lt_unsigned = i_a < i_b;

    always_comb begin
        case (i_op)
            ALU_ADD:  o_result = i_a + i_b;
            ALU_SUB:  o_result = i_a - i_b;
            ALU_SLL:  o_result = i_a << shamt;
            ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  o_result = i_a ^ i_b;
            ALU_SRL:  o_result = i_a >> shamt;
            ALU_SRA:  o_result = $signed(i_a) >>> shamt;
            ALU_OR:   o_result = i_a | i_b;
            ALU_AND:  o_result = i_a & i_b;
            default:  o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // Datapath and register file geometry
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int SHAMT_W    = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Only the two integer ALU opcodes are legal
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // funct3 encodings shared by OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // Source of an EX operand
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

endpackage

`default_nettype wire
